// ==== verilog/mac_cfg_pkg.sv ====
//--------------------------------------------------------------------
// Sizes and fixed constants of the int8 MAC engine
//--------------------------------------------------------------------
package mac_cfg_pkg;

    // Array geometry
    localparam int LANES     = 4;
    localparam int BYTE_W    = 8;       // int8 operands
    localparam int ACC_W     = 16;      // Result lane, wraps
    localparam int WORD_W    = 64;

    // Memory addressing
    localparam int RD_ADDR_W = 3;       // Weight and input memories
    localparam int WR_ADDR_W = 4;       // Output memory

    // Dimension fields of mnt
    localparam int DIM_W     = 4;

    // Input read request to output write request
    localparam int PIPE_LAT  = 3;

endpackage

// ==== verilog/mac_types_pkg.sv ====
//--------------------------------------------------------------------
// Packed structs, memory word union and FSM state of the MAC engine
//--------------------------------------------------------------------
package mac_types_pkg;

    // Dimensions, m in the top nibble
    typedef struct packed {
        logic [mac_cfg_pkg::DIM_W-1:0] m;
        logic [mac_cfg_pkg::DIM_W-1:0] n;
        logic [mac_cfg_pkg::DIM_W-1:0] t;
    } mnt_t;

    // One memory word, lane 0 in the top byte
    typedef union packed {
        logic [0:mac_cfg_pkg::WORD_W/mac_cfg_pkg::BYTE_W-1][mac_cfg_pkg::BYTE_W-1:0] bytes;
        struct packed {
            logic [mac_cfg_pkg::WORD_W/2-1:0] hi;
            logic [mac_cfg_pkg::WORD_W/2-1:0] lo;
        } halves;
    } mem_word_u;

    typedef logic [0:mac_cfg_pkg::LANES-1][mac_cfg_pkg::ACC_W-1:0] result_word_t;

    typedef struct packed {
        logic                              en;
        logic [mac_cfg_pkg::RD_ADDR_W-1:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                              en;
        logic [mac_cfg_pkg::WR_ADDR_W-1:0] addr;
        result_word_t                      wdata;
    } mem_wr_req_t;

    typedef struct packed {
        logic         valid;
        result_word_t word;
    } res_beat_t;

    typedef enum logic [2:0] {IDLE, LOAD_W, STREAM_I, DRAIN, FINISH} ctrl_state_t;

endpackage

// ==== verilog/mac_step_counter.sv ====
//--------------------------------------------------------------------
// Clearable step counter with last-step flag
//--------------------------------------------------------------------
`timescale 1ns/10ps

module mac_step_counter (
    input  logic                               CLK,
    input  logic                               RSTN,
    input  logic                               clear_i,
    input  logic                               step_i,
    input  logic [mac_cfg_pkg::DIM_W-1:0]      limit_i,
    output logic [mac_cfg_pkg::RD_ADDR_W-1:0]  count_o,
    output logic                               last_o
);

    logic [mac_cfg_pkg::DIM_W-1:0] count_ext;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            count_o <= '0;
        end else if (clear_i) begin                  // Clear wins
            count_o <= '0;
        end else if (step_i) begin
            count_o <= count_o + 1'b1;
        end
    end

    assign count_ext = {{(mac_cfg_pkg::DIM_W - mac_cfg_pkg::RD_ADDR_W){1'b0}}, count_o};
    assign last_o    = (count_ext == limit_i - 1'b1);

endmodule

// ==== verilog/mac_ctrl_fsm.sv ====
//--------------------------------------------------------------------
// Controller FSM: weight load, input stream, drain and done pulse
//--------------------------------------------------------------------
`timescale 1ns/10ps

module mac_ctrl_fsm (
    input  logic                               CLK,
    input  logic                               RSTN,
    input  logic                               start_i,
    input  mac_types_pkg::mnt_t                mnt_i,
    input  logic [mac_cfg_pkg::RD_ADDR_W-1:0]  cnt_i,
    input  logic                               cnt_last_i,
    input  logic                               store_last_i,
    output logic                               cnt_clear_o,
    output logic                               cnt_step_o,
    output logic [mac_cfg_pkg::DIM_W-1:0]      cnt_limit_o,
    output logic                               wb_clear_o,
    output mac_types_pkg::mem_rd_req_t         w_rd_o,
    output mac_types_pkg::mem_rd_req_t         i_rd_o,
    output logic                               done_o
);

    mac_types_pkg::ctrl_state_t state_q;
    mac_types_pkg::ctrl_state_t state_d;
    logic                       start_ok;
    logic                       reading;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            state_q <= mac_types_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mac_types_pkg::IDLE:     if (start_i) state_d = mac_types_pkg::LOAD_W;
            mac_types_pkg::LOAD_W:   if (cnt_last_i) state_d = mac_types_pkg::STREAM_I;
            mac_types_pkg::STREAM_I: if (cnt_last_i) state_d = mac_types_pkg::DRAIN;
            mac_types_pkg::DRAIN:    if (store_last_i) state_d = mac_types_pkg::FINISH;
            mac_types_pkg::FINISH:   state_d = mac_types_pkg::IDLE;
            default:                 state_d = mac_types_pkg::IDLE;
        endcase
    end

    //----------------------------------------------------------------
    // Counter control and read requests
    //----------------------------------------------------------------
    assign start_ok = (state_q == mac_types_pkg::IDLE) && start_i;
    assign reading  = (state_q == mac_types_pkg::LOAD_W) || (state_q == mac_types_pkg::STREAM_I);

    assign cnt_step_o  = reading;
    assign cnt_clear_o = start_ok || (reading && cnt_last_i);    // Each phase change
    assign cnt_limit_o = (state_q == mac_types_pkg::STREAM_I) ? mnt_i.t : mnt_i.m;
    assign wb_clear_o  = start_ok;

    assign w_rd_o = '{en: (state_q == mac_types_pkg::LOAD_W), addr: cnt_i};
    assign i_rd_o = '{en: (state_q == mac_types_pkg::STREAM_I), addr: cnt_i};

    assign done_o = (state_q == mac_types_pkg::FINISH);

endmodule

// ==== verilog/weight_bank.sv ====
//--------------------------------------------------------------------
// Stationary 4x4 weight registers with N and M masking
//--------------------------------------------------------------------
`timescale 1ns/10ps

module weight_bank (
    input  logic                           CLK,
    input  logic                           RSTN,
    input  logic                           clear_i,
    input  mac_types_pkg::mem_rd_req_t     w_rd_i,
    input  mac_types_pkg::mem_word_u       w_rdata_i,
    input  logic [mac_cfg_pkg::DIM_W-1:0]  n_i,
    output logic [0:mac_cfg_pkg::LANES-1][0:mac_cfg_pkg::LANES-1][mac_cfg_pkg::BYTE_W-1:0] weights_o
);

    mac_types_pkg::mem_rd_req_t w_rd_q;    // Row now on w_rdata_i
    mac_types_pkg::mem_word_u   row_word;
    logic [0:mac_cfg_pkg::LANES-1][0:mac_cfg_pkg::LANES-1][mac_cfg_pkg::BYTE_W-1:0] weights_q;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            w_rd_q <= '0;
        end else begin
            w_rd_q <= w_rd_i;
        end
    end

    // Upper half only, bytes at and beyond N forced to zero
    always_comb begin
        row_word           = '0;
        row_word.halves.hi = w_rdata_i.halves.hi;
        for (int n = 0; n < mac_cfg_pkg::LANES; n++) begin
            if (n >= int'(n_i)) row_word.bytes[n] = '0;
        end
    end

    // Rows never loaded stay zero, so lanes m >= M read zero
    always_ff @(posedge CLK) begin
        if (clear_i) begin
            weights_q <= '0;
        end else if (w_rd_q.en) begin
            weights_q[w_rd_q.addr] <= row_word.bytes[0:mac_cfg_pkg::LANES-1];
        end
    end

    assign weights_o = weights_q;

endmodule

// ==== verilog/mac_array.sv ====
//--------------------------------------------------------------------
// Two-stage multiply and lane-sum array
//--------------------------------------------------------------------
`timescale 1ns/10ps

module mac_array (
    input  logic                        CLK,
    input  logic                        RSTN,
    input  mac_types_pkg::mem_rd_req_t  i_rd_i,
    input  mac_types_pkg::mem_word_u    i_rdata_i,
    input  logic [0:mac_cfg_pkg::LANES-1][0:mac_cfg_pkg::LANES-1][mac_cfg_pkg::BYTE_W-1:0] weights_i,
    output mac_types_pkg::res_beat_t    res_o
);

    logic                               in_vld_q;    // Data on i_rdata_i is live
    logic                               prod_vld_q;
    logic                               sum_vld_q;
    logic [0:mac_cfg_pkg::LANES-1][0:mac_cfg_pkg::LANES-1][mac_cfg_pkg::ACC_W-1:0] prod_q;
    mac_types_pkg::result_word_t        sum_d;
    mac_types_pkg::result_word_t        sum_q;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            in_vld_q   <= 1'b0;
            prod_vld_q <= 1'b0;
            sum_vld_q  <= 1'b0;
        end else begin
            in_vld_q   <= i_rd_i.en;
            prod_vld_q <= in_vld_q;
            sum_vld_q  <= prod_vld_q;
        end
    end

    //----------------------------------------------------------------
    // Stage 1: signed int8 products
    //----------------------------------------------------------------
    always_ff @(posedge CLK) begin
        for (int m = 0; m < mac_cfg_pkg::LANES; m++) begin
            for (int n = 0; n < mac_cfg_pkg::LANES; n++) begin
                prod_q[m][n] <= $signed(i_rdata_i.bytes[n]) * $signed(weights_i[m][n]);
            end
        end
    end

    //----------------------------------------------------------------
    // Stage 2: lane sums, wrap to ACC_W
    //----------------------------------------------------------------
    always_comb begin
        for (int m = 0; m < mac_cfg_pkg::LANES; m++) begin
            sum_d[m] = '0;
            for (int n = 0; n < mac_cfg_pkg::LANES; n++) begin
                sum_d[m] = sum_d[m] + prod_q[m][n];
            end
        end
    end

    always_ff @(posedge CLK) begin
        sum_q <= sum_d;
    end

    assign res_o = '{valid: sum_vld_q, word: sum_q};

endmodule

// ==== verilog/result_store.sv ====
//--------------------------------------------------------------------
// Output memory writes at even addresses, last-write flag
//--------------------------------------------------------------------
`timescale 1ns/10ps

module result_store (
    input  logic                           CLK,
    input  logic                           RSTN,
    input  logic                           start_i,
    input  logic [mac_cfg_pkg::DIM_W-1:0]  t_i,
    input  mac_types_pkg::res_beat_t       res_i,
    output mac_types_pkg::mem_wr_req_t     o_wr_o,
    output logic                           store_last_o
);

    logic [mac_cfg_pkg::RD_ADDR_W-1:0] row_idx;
    logic                              row_last;

    // Index of the next row to be written
    mac_step_counter wr_cnt_inst (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .clear_i (start_i),
        .step_i  (res_i.valid),
        .limit_i (t_i),
        .count_o (row_idx),
        .last_o  (row_last)
    );

    // Row t goes to address 2*t
    assign o_wr_o = '{en: res_i.valid, addr: {row_idx, 1'b0}, wdata: res_i.word};

    assign store_last_o = res_i.valid && row_last;

endmodule

// ==== verilog/mac_top.sv ====
//--------------------------------------------------------------------
// MAC engine top: controller, address counter and datapath
//--------------------------------------------------------------------
`timescale 1ns/10ps

module mac_top (
    input  logic                        CLK,
    input  logic                        RSTN,
    input  mac_types_pkg::mnt_t         mnt_i,
    input  logic                        start_i,
    output logic                        done_o,
    output mac_types_pkg::mem_rd_req_t  w_rd_o,
    input  mac_types_pkg::mem_word_u    w_rdata_i,
    output mac_types_pkg::mem_rd_req_t  i_rd_o,
    input  mac_types_pkg::mem_word_u    i_rdata_i,
    output mac_types_pkg::mem_wr_req_t  o_wr_o
);

    logic [mac_cfg_pkg::RD_ADDR_W-1:0]  cnt;
    logic                               cnt_last;
    logic                               cnt_clear;
    logic                               cnt_step;
    logic [mac_cfg_pkg::DIM_W-1:0]      cnt_limit;
    logic                               wb_clear;     // Accepted start
    logic                               store_last;
    logic [0:mac_cfg_pkg::LANES-1][0:mac_cfg_pkg::LANES-1][mac_cfg_pkg::BYTE_W-1:0] weights;
    mac_types_pkg::res_beat_t           res;

    mac_ctrl_fsm ctrl_inst (
        .CLK          (CLK),
        .RSTN         (RSTN),
        .start_i      (start_i),
        .mnt_i        (mnt_i),
        .cnt_i        (cnt),
        .cnt_last_i   (cnt_last),
        .store_last_i (store_last),
        .cnt_clear_o  (cnt_clear),
        .cnt_step_o   (cnt_step),
        .cnt_limit_o  (cnt_limit),
        .wb_clear_o   (wb_clear),
        .w_rd_o       (w_rd_o),
        .i_rd_o       (i_rd_o),
        .done_o       (done_o)
    );

    // Read address for both weight and input phases
    mac_step_counter rd_cnt_inst (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .clear_i (cnt_clear),
        .step_i  (cnt_step),
        .limit_i (cnt_limit),
        .count_o (cnt),
        .last_o  (cnt_last)
    );

    weight_bank wb_inst (
        .CLK       (CLK),
        .RSTN      (RSTN),
        .clear_i   (wb_clear),
        .w_rd_i    (w_rd_o),
        .w_rdata_i (w_rdata_i),
        .n_i       (mnt_i.n),
        .weights_o (weights)
    );

    mac_array array_inst (
        .CLK       (CLK),
        .RSTN      (RSTN),
        .i_rd_i    (i_rd_o),
        .i_rdata_i (i_rdata_i),
        .weights_i (weights),
        .res_o     (res)
    );

    result_store store_inst (
        .CLK          (CLK),
        .RSTN         (RSTN),
        .start_i      (wb_clear),
        .t_i          (mnt_i.t),
        .res_i        (res),
        .o_wr_o       (o_wr_o),
        .store_last_o (store_last)
    );

endmodule

// ==== tb/mac_tb_mem.sv ====
//--------------------------------------------------------------------
// Weight, input and output memories with one-cycle read latency
//--------------------------------------------------------------------
`timescale 1ns/10ps

module mac_tb_mem (
    input  logic                        CLK,
    input  mac_types_pkg::mem_rd_req_t  w_rd_i,
    output mac_types_pkg::mem_word_u    w_rdata_o,
    input  mac_types_pkg::mem_rd_req_t  i_rd_i,
    output mac_types_pkg::mem_word_u    i_rdata_o,
    input  mac_types_pkg::mem_wr_req_t  o_wr_i
);

    mac_types_pkg::mem_word_u           w_mem [0:2**mac_cfg_pkg::RD_ADDR_W-1];
    mac_types_pkg::mem_word_u           i_mem [0:2**mac_cfg_pkg::RD_ADDR_W-1];
    logic [mac_cfg_pkg::WR_ADDR_W-1:0]  log_addr [0:63];    // Output writes in order
    mac_types_pkg::result_word_t        log_data [0:63];
    int                                 log_n = 0;

    initial begin
        w_rdata_o = '0;
        i_rdata_o = '0;
    end

    always @(posedge CLK) begin
        if (w_rd_i.en) w_rdata_o <= w_mem[w_rd_i.addr];
        if (i_rd_i.en) i_rdata_o <= i_mem[i_rd_i.addr];
        if (o_wr_i.en && log_n < 64) begin
            log_addr[log_n] <= o_wr_i.addr;
            log_data[log_n] <= o_wr_i.wdata;
            log_n           <= log_n + 1;
        end
    end

endmodule

// ==== tb/mac_top_tb.sv ====
//--------------------------------------------------------------------
// MAC engine testbench with stimulus, reference model and write checks
//--------------------------------------------------------------------
`timescale 1ns/10ps

module mac_top_tb;

    localparam int NUM_TESTS = 10;
    localparam int RUN_MAX   = 2 * mac_cfg_pkg::LANES + mac_cfg_pkg::PIPE_LAT + 20;

    logic                        CLK;
    logic                        RSTN;
    logic                        start;
    logic                        done;
    mac_types_pkg::mnt_t         mnt;
    mac_types_pkg::mem_rd_req_t  w_rd;
    mac_types_pkg::mem_rd_req_t  i_rd;
    mac_types_pkg::mem_word_u    w_rdata;
    mac_types_pkg::mem_word_u    i_rdata;
    mac_types_pkg::mem_wr_req_t  o_wr;

    mac_types_pkg::mem_word_u    w_words [0:7];
    mac_types_pkg::mem_word_u    x_words [0:7];
    mac_types_pkg::mnt_t         cur_dims = '0;
    int                          row_base = 0;   // Log index of row 0 of this run
    int                          chk_n = 0;
    int                          err_cnt = 0;
    int                          fail_cnt = 0;
    int                          test_cnt = 0;
    int                          cyc = 0;

    mac_top mac_top_inst (
        .CLK       (CLK),
        .RSTN      (RSTN),
        .mnt_i     (mnt),
        .start_i   (start),
        .done_o    (done),
        .w_rd_o    (w_rd),
        .w_rdata_i (w_rdata),
        .i_rd_o    (i_rd),
        .i_rdata_i (i_rdata),
        .o_wr_o    (o_wr)
    );

    mac_tb_mem mem_inst (
        .CLK       (CLK),
        .w_rd_i    (w_rd),
        .w_rdata_o (w_rdata),
        .i_rd_i    (i_rd),
        .i_rdata_o (i_rdata),
        .o_wr_i    (o_wr)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) cyc <= cyc + 1;

    //----------------------------------------------------------------
    // Reference model and compare tasks
    //----------------------------------------------------------------
    function automatic mac_types_pkg::result_word_t ref_row(input mac_types_pkg::mnt_t dims,
                                                            input mac_types_pkg::mem_word_u x);
        mac_types_pkg::result_word_t res;
        int acc;
        int xa;
        int wa;
        res = '0;
        for (int m = 0; m < mac_cfg_pkg::LANES && m < int'(dims.m); m++) begin
            acc = 0;
            for (int n = 0; n < mac_cfg_pkg::LANES && n < int'(dims.n); n++) begin
                xa  = $signed(x.bytes[n]);
                wa  = $signed(w_words[m].bytes[n]);
                acc = acc + xa * wa;
            end
            res[m] = acc[mac_cfg_pkg::ACC_W-1:0];   // Wraps like the hardware lane
        end
        return res;
    endfunction

    task automatic check_word(input mac_types_pkg::result_word_t got,
                              input mac_types_pkg::result_word_t exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got %h expected %h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input logic [mac_cfg_pkg::WR_ADDR_W-1:0] got,
                              input logic [mac_cfg_pkg::WR_ADDR_W-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s got %0d expected %0d", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_done(input int got, input int exp, input string msg);
        if (got != exp) begin
            $display("MISMATCH @%0t: %s got %0d cycles expected %0d", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_quiet(input mac_types_pkg::mem_rd_req_t w,
                               input mac_types_pkg::mem_rd_req_t i,
                               input mac_types_pkg::mem_wr_req_t o,
                               input logic d, input string msg);
        if (w.en !== 1'b0 || i.en !== 1'b0 || o.en !== 1'b0 || d !== 1'b0) begin
            $display("MISMATCH @%0t: %s, w/i/o enables %b%b%b done %b",
                     $time, msg, w.en, i.en, o.en, d);
            err_cnt++;
        end
    endtask

    // Each logged write against row (index - row_base) of the current run
    initial begin : compare_writes
        int row;
        forever begin
            @(negedge CLK);
            while (chk_n < mem_inst.log_n) begin
                row = chk_n - row_base;
                if (row < 0 || row >= int'(cur_dims.t)) begin
                    $display("@%0t: unexpected output write number %0d", $time, chk_n);
                    err_cnt++;
                end else begin
                    check_addr(mem_inst.log_addr[chk_n], 4'(2 * row),
                               $sformatf("row %0d address", row));
                    check_word(mem_inst.log_data[chk_n], ref_row(cur_dims, x_words[row]),
                               $sformatf("row %0d result", row));
                end
                chk_n++;
            end
        end
    end

    //----------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------
    function automatic logic [7:0] extreme_byte();
        case ($urandom % 4)
            0:       return 8'h80;
            1:       return 8'h7f;
            2:       return 8'hff;
            default: return 8'h01;
        endcase
    endfunction

    // Mode 0 random, 1 all -128, 2 mixed extremes over all bytes of all 8 words
    task automatic fill_words(input int mode);
        for (int a = 0; a < 8; a++) begin
            for (int b = 0; b < 8; b++) begin
                case (mode)
                    0: begin
                        w_words[a].bytes[b] = 8'($urandom);
                        x_words[a].bytes[b] = 8'($urandom);
                    end
                    1: begin
                        w_words[a].bytes[b] = 8'h80;
                        x_words[a].bytes[b] = 8'h80;
                    end
                    default: begin
                        w_words[a].bytes[b] = extreme_byte();
                        x_words[a].bytes[b] = extreme_byte();
                    end
                endcase
            end
            mem_inst.w_mem[a] = w_words[a];
            mem_inst.i_mem[a] = x_words[a];
        end
    endtask

    task automatic report(input string name, input int base_err);
        test_cnt++;
        if (err_cnt == base_err) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, err_cnt - base_err);
            fail_cnt++;
        end
    endtask

    task automatic run_case(input string name, input mac_types_pkg::mnt_t dims,
                            input int mode, input bit poke);
        int base_err;
        int start_cyc;
        int done_cyc;
        int n_wr;
        base_err = err_cnt;
        @(posedge CLK);
        #2;
        fill_words(mode);
        cur_dims  = dims;
        row_base  = mem_inst.log_n;
        mnt       = dims;
        start     = 1'b1;
        start_cyc = cyc;
        @(posedge CLK);
        #2;
        start = 1'b0;
        if (poke) begin
            repeat (3) @(posedge CLK);
            #2;
            start = 1'b1;      // Start during a run is ignored
            @(posedge CLK);
            #2;
            start = 1'b0;
        end
        done_cyc = -1;
        for (int k = 0; k < RUN_MAX && done_cyc < 0; k++) begin
            @(negedge CLK);
            if (done) done_cyc = cyc;
        end
        if (done_cyc < 0) begin
            $display("%s: done_o never went high", name);
            err_cnt++;
        end else begin
            check_done(done_cyc - start_cyc, int'(dims.m) + int'(dims.t) + 4, {name, " done"});
        end
        @(negedge CLK);
        check_quiet(w_rd, i_rd, o_wr, done, {name, " idle after done"});
        n_wr = mem_inst.log_n - row_base;
        if (n_wr != int'(dims.t)) begin
            $display("MISMATCH @%0t: %s wrote %0d rows expected %0d", $time, name, n_wr, dims.t);
            err_cnt++;
        end
        report(name, base_err);
    endtask

    initial begin : main_seq
        mac_types_pkg::mnt_t dims;
        void'($urandom(32'hdb7803bf));
        RSTN  = 1'b0;
        start = 1'b0;
        mnt   = '0;
        repeat (3) begin
            @(posedge CLK);
            #2;
            check_quiet(w_rd, i_rd, o_wr, done, "in reset");
        end
        RSTN = 1'b1;
        repeat (2) begin
            @(negedge CLK);
            check_quiet(w_rd, i_rd, o_wr, done, "idle after reset");
        end
        report("reset_idle", 0);

        dims = '{m: 4'd4, n: 4'd4, t: 4'd4};
        run_case("full", dims, 0, 1'b0);
        repeat (3) begin
            dims = '{m: 4'(1 + $urandom % 3), n: 4'(1 + $urandom % 3), t: 4'(1 + $urandom % 4)};
            run_case("masked", dims, 0, 1'b0);
        end
        dims = '{m: 4'(1 + $urandom % 4), n: 4'(1 + $urandom % 4), t: 4'd1};
        run_case("t_one", dims, 0, 1'b0);
        dims.t = 4'd4;
        run_case("t_four", dims, 0, 1'b0);
        dims = '{m: 4'd4, n: 4'd4, t: 4'd4};
        run_case("neg_wrap", dims, 1, 1'b0);
        dims = '{m: 4'(1 + $urandom % 4), n: 4'(1 + $urandom % 4), t: 4'd4};
        run_case("mixed_sign", dims, 2, 1'b0);
        dims = '{m: 4'd4, n: 4'd4, t: 4'd4};
        run_case("mid_start", dims, 0, 1'b1);

        $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_TESTS * RUN_MAX * 40);
        $display("watchdog expired after %0d cycles, run did not finish", NUM_TESTS * RUN_MAX);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== mac_top.f ====
verilog/mac_cfg_pkg.sv
verilog/mac_types_pkg.sv
verilog/mac_step_counter.sv
verilog/mac_ctrl_fsm.sv
verilog/weight_bank.sv
verilog/mac_array.sv
verilog/result_store.sv
verilog/mac_top.sv
tb/mac_tb_mem.sv
tb/mac_top_tb.sv
